// ==== hw/clint_pkg.sv ====
// clint package with bus widths, the register address map and the shared enums
package clint_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // request address, covers the full 64 KB clint window
  localparam int CLINT_ADDR_W = 16;
  // every access is one full 32-bit word
  localparam int CLINT_DATA_W = 32;
  // machine timer and per-hart compare width
  localparam int CLINT_MTIME_W = 64;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  // msip words, one per hart, stride 4
  localparam logic [CLINT_ADDR_W-1:0] CLINT_MSIP_BASE = 16'h0000;

  // mtimecmp pairs, one per hart, stride 8
  // low word first, high word at +4
  localparam logic [CLINT_ADDR_W-1:0] CLINT_MTIMECMP_BASE = 16'h4000;

  // shared machine timer, low and high halves
  localparam logic [CLINT_ADDR_W-1:0] CLINT_MTIME_LO = 16'hBFF8;
  localparam logic [CLINT_ADDR_W-1:0] CLINT_MTIME_HI = 16'hBFFC;

  ////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////

  // request opcode carried on the request channel
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } clint_op_e;

  // register kind inside one hart slot
  // only bit 0 of msip is writable, the rest reads as zero
  typedef enum logic [1:0] {
    REG_MSIP        = 2'd0,
    REG_MTIMECMP_LO = 2'd1,
    REG_MTIMECMP_HI = 2'd2
  } slot_reg_e;

endpackage

// ==== hw/clint_req_decode.sv ====
// clint request decoder, accepts requests, owns mtime and loads the decode stage
module clint_req_decode #(
  parameter int N_HARTS = 4
) (
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  // request channel
  input  logic                                 i_req_valid,
  output logic                                 o_req_ready,
  input  clint_pkg::clint_op_e                 i_req_op,
  input  logic [clint_pkg::CLINT_ADDR_W-1:0]   i_req_addr,
  input  logic [clint_pkg::CLINT_DATA_W-1:0]   i_req_wdata,
  // common pipeline advance, computed in the collector
  input  logic                                 i_adv,
  input  logic                                 i_rtc_tick,
  // decode stage toward the hart slots
  output logic                                 o_slot_valid,
  output logic [N_HARTS-1:0]                   o_slot_sel,
  output clint_pkg::clint_op_e                 o_slot_op,
  output clint_pkg::slot_reg_e                 o_slot_reg,
  output logic [clint_pkg::CLINT_DATA_W-1:0]   o_slot_wdata,
  output logic [clint_pkg::CLINT_MTIME_W-1:0]  o_mtime,
  // decode stage toward the collector
  output logic                                 o_local_valid,
  output logic [clint_pkg::CLINT_DATA_W-1:0]   o_local_rdata,
  output logic                                 o_local_err
);

  import clint_pkg::*;

  // hart count at address width for the index compares
  localparam logic [CLINT_ADDR_W-1:0] NH = CLINT_ADDR_W'(N_HARTS);

  logic                     acc;
  logic                     is_wr;
  logic [CLINT_ADDR_W-1:0]  msip_off;
  logic [CLINT_ADDR_W-1:0]  cmp_off;
  logic [CLINT_ADDR_W-1:0]  msip_idx;
  logic [CLINT_ADDR_W-1:0]  cmp_idx;
  logic [CLINT_ADDR_W-1:0]  hart_idx;
  logic                     hit_msip;
  logic                     hit_cmp;
  logic                     hit_lo;
  logic                     hit_hi;
  logic                     hit_slot;
  logic [N_HARTS-1:0]       sel_d;
  slot_reg_e                reg_d;
  logic [CLINT_DATA_W-1:0]  local_rdata_d;
  logic [CLINT_MTIME_W-1:0] mtime_q;

  ////////////////////////////////////////////////////////////
  // handshake and address decode
  ////////////////////////////////////////////////////////////

  // ready is simply the shared advance
  assign o_req_ready = i_adv;
  assign acc         = i_req_valid && i_adv;
  assign is_wr       = (i_req_op == OP_WRITE);

  // offsets wrap below the base, so the index compare rejects them too
  assign msip_off = i_req_addr - CLINT_MSIP_BASE;
  assign cmp_off  = i_req_addr - CLINT_MTIMECMP_BASE;
  assign msip_idx = {2'b00, msip_off[CLINT_ADDR_W-1:2]};
  assign cmp_idx  = {3'b000, cmp_off[CLINT_ADDR_W-1:3]};

  // word aligned and hart index below N_HARTS
  assign hit_msip = (msip_off[1:0] == 2'b00) && (msip_idx < NH);
  assign hit_cmp  = (cmp_off[1:0] == 2'b00) && (cmp_idx < NH);
  assign hit_lo   = (i_req_addr == CLINT_MTIME_LO);
  assign hit_hi   = (i_req_addr == CLINT_MTIME_HI);
  assign hit_slot = hit_msip || hit_cmp;

  // one-hot slot select and register kind
  assign hart_idx = hit_msip ? msip_idx : cmp_idx;
  assign sel_d    = hit_slot ? (N_HARTS'(1) << hart_idx) : '0;
  assign reg_d    = hit_msip   ? REG_MSIP :
                    cmp_off[2] ? REG_MTIMECMP_HI : REG_MTIMECMP_LO;

  // local read data, mtime as it stands before this edge
  // writes and errors return zero
  always_comb
  begin
    local_rdata_d = '0;
    if (!is_wr && hit_lo)
      local_rdata_d = mtime_q[CLINT_DATA_W-1:0];
    else if (!is_wr && hit_hi)
      local_rdata_d = mtime_q[CLINT_MTIME_W-1:CLINT_DATA_W];
  end

  ////////////////////////////////////////////////////////////
  // decode stage
  ////////////////////////////////////////////////////////////

  // valid bits, empty bubble when advancing without a request
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      o_slot_valid  <= 1'b0;
      o_slot_sel    <= '0;
      o_local_valid <= 1'b0;
    end
    else if (i_adv)
    begin
      o_slot_valid  <= acc && hit_slot;
      o_slot_sel    <= acc ? sel_d : '0;
      o_local_valid <= acc && !hit_slot;
    end
  end

  // payload, qualified downstream by the valid bits
  always_ff @(posedge i_clk)
  begin
    if (i_adv)
    begin
      o_slot_op     <= i_req_op;
      o_slot_reg    <= reg_d;
      o_slot_wdata  <= i_req_wdata;
      o_local_rdata <= local_rdata_d;
      o_local_err   <= !(hit_slot || hit_lo || hit_hi);
    end
  end

  ////////////////////////////////////////////////////////////
  // machine timer
  ////////////////////////////////////////////////////////////

  // a write on the accept edge beats the tick
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      mtime_q <= '0;
    else if (acc && is_wr && hit_lo)
      mtime_q[CLINT_DATA_W-1:0] <= i_req_wdata;
    else if (acc && is_wr && hit_hi)
      mtime_q[CLINT_MTIME_W-1:CLINT_DATA_W] <= i_req_wdata;
    else if (i_rtc_tick)
      mtime_q <= mtime_q + 1'b1;
  end

  assign o_mtime = mtime_q;

  // at most one slot selected, and none while a local result is in the stage
  a_sel_onehot : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(o_slot_sel) && !(o_local_valid && (o_slot_sel != '0))
  );

endmodule

// ==== hw/clint_hart_slot.sv ====
// clint hart slot, msip and mtimecmp registers, timer compare and slot read data
module clint_hart_slot (
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  // common pipeline advance
  input  logic                                 i_adv,
  // decode stage fields
  input  logic                                 i_valid,
  input  logic                                 i_sel,
  input  clint_pkg::clint_op_e                 i_op,
  input  clint_pkg::slot_reg_e                 i_reg,
  input  logic [clint_pkg::CLINT_DATA_W-1:0]   i_wdata,
  // shared machine timer
  input  logic [clint_pkg::CLINT_MTIME_W-1:0]  i_mtime,
  // slot stage read result
  output logic                                 o_rd_valid,
  output logic [clint_pkg::CLINT_DATA_W-1:0]   o_rdata,
  // interrupt lines of this hart
  output logic                                 o_msip,
  output logic                                 o_mtip
);

  import clint_pkg::*;

  logic                     hit;
  logic                     wr_en;
  logic                     rd_en;
  logic                     msip_q;
  logic [CLINT_MTIME_W-1:0] mtimecmp_q;
  logic [CLINT_DATA_W-1:0]  rd_mux;

  ////////////////////////////////////////////////////////////
  // access qualification
  ////////////////////////////////////////////////////////////

  // this hart addressed by a live decode stage entry
  assign hit   = i_valid && i_sel;
  // writes land on the edge that moves the entry into the slot stage
  assign wr_en = i_adv && hit && (i_op == OP_WRITE);
  assign rd_en = i_adv && hit && (i_op == OP_READ);

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  // compare resets to all ones so mtip stays low until programmed
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
    end
    else if (wr_en)
    begin
      case (i_reg)
        REG_MSIP:
          msip_q <= i_wdata[0];
        REG_MTIMECMP_LO:
          mtimecmp_q[CLINT_DATA_W-1:0] <= i_wdata;
        REG_MTIMECMP_HI:
          mtimecmp_q[CLINT_MTIME_W-1:CLINT_DATA_W] <= i_wdata;
        default:
        begin
          // unused encoding, nothing to write
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  // register select, msip zero extended
  always_comb
  begin
    case (i_reg)
      REG_MSIP:        rd_mux = {{(CLINT_DATA_W-1){1'b0}}, msip_q};
      REG_MTIMECMP_LO: rd_mux = mtimecmp_q[CLINT_DATA_W-1:0];
      REG_MTIMECMP_HI: rd_mux = mtimecmp_q[CLINT_MTIME_W-1:CLINT_DATA_W];
      default:         rd_mux = '0;
    endcase
  end

  // slot stage read valid
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      o_rd_valid <= 1'b0;
    else if (i_adv)
      o_rd_valid <= rd_en;
  end

  // zero when not read here, so the collector can simply OR all slots
  always_ff @(posedge i_clk)
  begin
    if (i_adv)
      o_rdata <= rd_en ? rd_mux : '0;
  end

  ////////////////////////////////////////////////////////////
  // interrupt outputs
  ////////////////////////////////////////////////////////////

  assign o_msip = msip_q;
  // timer pending while mtime has reached the compare value
  assign o_mtip = (i_mtime >= mtimecmp_q);

  // state only moves on an edge that advances this hart while selected
  a_hold_unselected : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    !(i_sel && i_adv) |=> $stable(msip_q) && $stable(mtimecmp_q)
  );

endmodule

// ==== hw/clint_rsp_collect.sv ====
// clint response collector, local mirror, slot data merge and response register
module clint_rsp_collect #(
  parameter int N_HARTS = 4
) (
  input  logic                                            i_clk,
  input  logic                                            i_rst_n,
  // response side flow control
  input  logic                                            i_rsp_ready,
  output logic                                            o_adv,
  // local result from the decode stage
  input  logic                                            i_local_valid,
  input  logic [clint_pkg::CLINT_DATA_W-1:0]              i_local_rdata,
  input  logic                                            i_local_err,
  // slot traffic in the decode stage
  input  logic                                            i_slot_valid,
  // slot stage read results
  input  logic [N_HARTS-1:0]                              i_rd_valid,
  input  logic [N_HARTS-1:0][clint_pkg::CLINT_DATA_W-1:0] i_rdata,
  // response channel
  output logic                                            o_rsp_valid,
  output logic [clint_pkg::CLINT_DATA_W-1:0]              o_rsp_rdata,
  output logic                                            o_rsp_err
);

  import clint_pkg::*;

  logic                    loc_vld_q;
  logic                    slot_vld_q;
  logic [CLINT_DATA_W-1:0] loc_rdata_q;
  logic                    loc_err_q;
  logic [CLINT_DATA_W-1:0] slot_rd_or;
  logic                    stage_vld;

  // whole pipe moves when the response register is free or being drained
  assign o_adv = !o_rsp_valid || i_rsp_ready;

  ////////////////////////////////////////////////////////////
  // slot stage mirror of local results
  ////////////////////////////////////////////////////////////

  // keeps local results in step with the slot registers
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      loc_vld_q  <= 1'b0;
      slot_vld_q <= 1'b0;
    end
    else if (o_adv)
    begin
      loc_vld_q  <= i_local_valid;
      slot_vld_q <= i_slot_valid;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (o_adv)
    begin
      loc_rdata_q <= i_local_rdata;
      loc_err_q   <= i_local_err;
    end
  end

  ////////////////////////////////////////////////////////////
  // merge and response register
  ////////////////////////////////////////////////////////////

  // at most one slot reads per entry, the rest contribute zero
  always_comb
  begin
    slot_rd_or = '0;
    for (int h = 0; h < N_HARTS; h++)
    begin
      if (i_rd_valid[h])
        slot_rd_or = slot_rd_or | i_rdata[h];
    end
  end

  // a write to a slot has no read data but still needs a response
  assign stage_vld = loc_vld_q || slot_vld_q;

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      o_rsp_valid <= 1'b0;
    else if (o_adv)
      o_rsp_valid <= stage_vld;
  end

  // fields frozen while the master stalls
  always_ff @(posedge i_clk)
  begin
    if (o_adv)
    begin
      o_rsp_rdata <= slot_rd_or | (loc_vld_q ? loc_rdata_q : '0);
      o_rsp_err   <= loc_vld_q && loc_err_q;
    end
  end

  // a stalled response keeps valid and its fields until taken
  a_rsp_hold : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_rsp_valid && !i_rsp_ready |=>
      o_rsp_valid && $stable(o_rsp_rdata) && $stable(o_rsp_err)
  );

endmodule

// ==== hw/clint_cluster.sv ====
// clint cluster top, request decoder, per-hart slots and response collector
module clint_cluster #(
  parameter int N_HARTS = 4
) (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  // request channel
  input  logic                                i_req_valid,
  output logic                                o_req_ready,
  input  clint_pkg::clint_op_e                i_req_op,
  input  logic [clint_pkg::CLINT_ADDR_W-1:0]  i_req_addr,
  input  logic [clint_pkg::CLINT_DATA_W-1:0]  i_req_wdata,
  // response channel
  output logic                                o_rsp_valid,
  input  logic                                i_rsp_ready,
  output logic [clint_pkg::CLINT_DATA_W-1:0]  o_rsp_rdata,
  output logic                                o_rsp_err,
  // timer tick and interrupt lines
  input  logic                                i_rtc_tick,
  output logic [N_HARTS-1:0]                  o_msip,
  output logic [N_HARTS-1:0]                  o_mtip
);

  import clint_pkg::*;

  logic                                 adv;
  // decode stage
  logic                                 slot_valid;
  logic [N_HARTS-1:0]                   slot_sel;
  clint_op_e                            slot_op;
  slot_reg_e                            slot_reg;
  logic [CLINT_DATA_W-1:0]              slot_wdata;
  logic [CLINT_MTIME_W-1:0]             mtime;
  logic                                 local_valid;
  logic [CLINT_DATA_W-1:0]              local_rdata;
  logic                                 local_err;
  // slot stage
  logic [N_HARTS-1:0]                   rd_valid;
  logic [N_HARTS-1:0][CLINT_DATA_W-1:0] slot_rdata;

  ////////////////////////////////////////////////////////////
  // request decoder and mtime owner
  ////////////////////////////////////////////////////////////

  clint_req_decode #(
    .N_HARTS(N_HARTS)
  ) u_decode (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_req_valid   (i_req_valid),
    .o_req_ready   (o_req_ready),
    .i_req_op      (i_req_op),
    .i_req_addr    (i_req_addr),
    .i_req_wdata   (i_req_wdata),
    .i_adv         (adv),
    .i_rtc_tick    (i_rtc_tick),
    .o_slot_valid  (slot_valid),
    .o_slot_sel    (slot_sel),
    .o_slot_op     (slot_op),
    .o_slot_reg    (slot_reg),
    .o_slot_wdata  (slot_wdata),
    .o_mtime       (mtime),
    .o_local_valid (local_valid),
    .o_local_rdata (local_rdata),
    .o_local_err   (local_err)
  );

  ////////////////////////////////////////////////////////////
  // one slot per hart
  ////////////////////////////////////////////////////////////

  for (genvar h = 0; h < N_HARTS; h++)
  begin : g_hart
    clint_hart_slot u_slot (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_adv      (adv),
      .i_valid    (slot_valid),
      .i_sel      (slot_sel[h]),
      .i_op       (slot_op),
      .i_reg      (slot_reg),
      .i_wdata    (slot_wdata),
      .i_mtime    (mtime),
      .o_rd_valid (rd_valid[h]),
      .o_rdata    (slot_rdata[h]),
      .o_msip     (o_msip[h]),
      .o_mtip     (o_mtip[h])
    );
  end

  ////////////////////////////////////////////////////////////
  // response collector, also the source of the advance
  ////////////////////////////////////////////////////////////

  clint_rsp_collect #(
    .N_HARTS(N_HARTS)
  ) u_collect (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_rsp_ready   (i_rsp_ready),
    .o_adv         (adv),
    .i_local_valid (local_valid),
    .i_local_rdata (local_rdata),
    .i_local_err   (local_err),
    .i_slot_valid  (slot_valid),
    .i_rd_valid    (rd_valid),
    .i_rdata       (slot_rdata),
    .o_rsp_valid   (o_rsp_valid),
    .o_rsp_rdata   (o_rsp_rdata),
    .o_rsp_err     (o_rsp_err)
  );

endmodule

// ==== bench/tb_clint_cluster.sv ====
// testbench for the clint cluster with seeded random register traffic checked against a model
module tb_clint_cluster;

  timeunit 1ns;
  timeprecision 100ps;

  import clint_pkg::*;

  localparam int N_HARTS     = 4;
  localparam int RST_CYCLES  = 10;
  // requests issued by each test
  localparam int N_READ_ALL  = 3 * N_HARTS + 2;
  localparam int N_T1        = N_READ_ALL;
  localparam int N_T2        = 80;
  localparam int N_T3_ROUNDS = 4;
  localparam int N_T3        = N_HARTS + N_T3_ROUNDS * 12;
  localparam int N_T4        = 40 + N_READ_ALL;
  localparam int N_T5        = 100;
  localparam int TOTAL_REQ   = N_T1 + N_T2 + N_T3 + N_T4 + N_T5;
  localparam int LIMIT       = 20 * TOTAL_REQ + 200;
  // address kinds seen by the model
  localparam int K_MSIP   = 0;
  localparam int K_CMP_LO = 1;
  localparam int K_CMP_HI = 2;
  localparam int K_MT_LO  = 3;
  localparam int K_MT_HI  = 4;
  localparam int K_ERR    = 5;

  logic                    i_clk;
  logic                    i_rst_n;
  logic                    i_req_valid;
  logic                    o_req_ready;
  clint_op_e               i_req_op;
  logic [CLINT_ADDR_W-1:0] i_req_addr;
  logic [CLINT_DATA_W-1:0] i_req_wdata;
  logic                    o_rsp_valid;
  logic                    i_rsp_ready;
  logic [CLINT_DATA_W-1:0] o_rsp_rdata;
  logic                    o_rsp_err;
  logic                    i_rtc_tick;
  logic [N_HARTS-1:0]      o_msip;
  logic [N_HARTS-1:0]      o_mtip;

  // reference model state
  logic [CLINT_MTIME_W-1:0] m_mtime;
  logic [CLINT_MTIME_W-1:0] m_cmp [N_HARTS];
  logic [N_HARTS-1:0]       m_msip;
  logic [CLINT_DATA_W-1:0]  exp_rdata_q [$];
  logic                     exp_err_q [$];

  // stimulus state
  integer                  seed = 46;
  int                      valid_pct;
  int                      ready_pct;
  int                      tick_pct;
  bit                      have_req;
  bit                      req_taken;
  clint_op_e               nxt_op;
  logic [CLINT_ADDR_W-1:0] nxt_addr;
  logic [CLINT_DATA_W-1:0] nxt_wdata;
  int                      n_checks;
  int                      n_errors;
  int                      cycle_cnt;
  int                      err0;

  clint_cluster #(
    .N_HARTS(N_HARTS)
  ) u_dut (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req_op    (i_req_op),
    .i_req_addr  (i_req_addr),
    .i_req_wdata (i_req_wdata),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp_rdata (o_rsp_rdata),
    .o_rsp_err   (o_rsp_err),
    .i_rtc_tick  (i_rtc_tick),
    .o_msip      (o_msip),
    .o_mtip      (o_mtip)
  );

  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////

  initial cycle_cnt = 0;
  always @(posedge i_clk) cycle_cnt <= cycle_cnt + 1;

  initial
  begin
    wait (cycle_cnt >= RST_CYCLES + LIMIT);
    $display("timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // random helpers and address map of the model
  ////////////////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic bit rand_pct(input int p);
    return rand_below(100) < p;
  endfunction

  // kind and hart index of an address straight from the register map
  function automatic int addr_kind(input logic [CLINT_ADDR_W-1:0] a, output int h);
    int ia;
    ia = int'(a);
    h  = 0;
    if (a[1:0] != 2'b00)
      return K_ERR;
    if (ia >= int'(CLINT_MSIP_BASE) && ia < int'(CLINT_MSIP_BASE) + 4 * N_HARTS)
    begin
      h = (ia - int'(CLINT_MSIP_BASE)) / 4;
      return K_MSIP;
    end
    if (ia >= int'(CLINT_MTIMECMP_BASE) && ia < int'(CLINT_MTIMECMP_BASE) + 8 * N_HARTS)
    begin
      h = (ia - int'(CLINT_MTIMECMP_BASE)) / 8;
      return a[2] ? K_CMP_HI : K_CMP_LO;
    end
    if (a == CLINT_MTIME_LO)
      return K_MT_LO;
    if (a == CLINT_MTIME_HI)
      return K_MT_HI;
    return K_ERR;
  endfunction

  function automatic logic [CLINT_ADDR_W-1:0] slot_addr(input int kind, input int h);
    if (kind == K_MSIP)
      return CLINT_ADDR_W'(int'(CLINT_MSIP_BASE) + 4 * h);
    return CLINT_ADDR_W'(int'(CLINT_MTIMECMP_BASE) + 8 * h + ((kind == K_CMP_HI) ? 4 : 0));
  endfunction

  // misaligned, hart out of range, or a hole in the map
  function automatic logic [CLINT_ADDR_W-1:0] bad_addr();
    case (rand_below(4))
      0: return slot_addr(rand_below(3), rand_below(N_HARTS)) + CLINT_ADDR_W'(1 + rand_below(3));
      1: return CLINT_ADDR_W'(int'(CLINT_MSIP_BASE) + 4 * (N_HARTS + rand_below(64)));
      2: return CLINT_ADDR_W'(int'(CLINT_MTIMECMP_BASE) + 8 * (N_HARTS + rand_below(64)));
      default: return CLINT_ADDR_W'(32'h8000 + 4 * rand_below(32'h0FFC));
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_rsp(input logic [CLINT_DATA_W-1:0] exp_rdata, input logic exp_err);
    n_checks++;
    if (o_rsp_rdata !== exp_rdata)
    begin
      n_errors++;
      $display("Mismatch at %0t: o_rsp_rdata expected %h got %h", $time, exp_rdata, o_rsp_rdata);
    end
    if (o_rsp_err !== exp_err)
    begin
      n_errors++;
      $display("Mismatch at %0t: o_rsp_err expected %b got %b", $time, exp_err, o_rsp_err);
    end
  endtask

  task automatic check_irq(input string name, input logic [N_HARTS-1:0] exp,
                           input logic [N_HARTS-1:0] got);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // model and cycle engine
  ////////////////////////////////////////////////////////////

  // apply the accepted request in order
  // reads see the state before the edge
  task automatic model_accept(output bit mt_wr);
    int                      kind;
    int                      h;
    bit                      wr;
    logic [CLINT_DATA_W-1:0] rd;
    kind  = addr_kind(i_req_addr, h);
    wr    = (i_req_op == OP_WRITE);
    rd    = '0;
    mt_wr = 1'b0;
    case (kind)
      K_MSIP:
        if (wr)
          m_msip[h] = i_req_wdata[0];
        else
          rd = {31'b0, m_msip[h]};
      K_CMP_LO:
        if (wr)
          m_cmp[h][31:0] = i_req_wdata;
        else
          rd = m_cmp[h][31:0];
      K_CMP_HI:
        if (wr)
          m_cmp[h][63:32] = i_req_wdata;
        else
          rd = m_cmp[h][63:32];
      K_MT_LO:
        if (wr)
          m_mtime[31:0] = i_req_wdata;
        else
          rd = m_mtime[31:0];
      K_MT_HI:
        if (wr)
          m_mtime[63:32] = i_req_wdata;
        else
          rd = m_mtime[63:32];
      default:
        rd = '0;
    endcase
    mt_wr = wr && (kind == K_MT_LO || kind == K_MT_HI);
    exp_rdata_q.push_back(rd);
    exp_err_q.push_back(kind == K_ERR);
  endtask

  // sampled at the falling edge to describe what the next rising edge does
  task automatic observe();
    bit                      mt_wr;
    logic [CLINT_DATA_W-1:0] e_rd;
    logic                    e_err;
    mt_wr = 1'b0;
    if (o_rsp_valid && i_rsp_ready)
    begin
      if (exp_rdata_q.size() == 0)
      begin
        n_errors++;
        $display("at %0t the DUT gave a response that no request asked for", $time);
      end
      else
      begin
        e_rd  = exp_rdata_q.pop_front();
        e_err = exp_err_q.pop_front();
        check_rsp(e_rd, e_err);
      end
    end
    if (i_req_valid && o_req_ready)
    begin
      model_accept(mt_wr);
      have_req  = 1'b0;
      req_taken = 1'b1;
    end
    // an mtime write beats the tick
    if (i_rtc_tick && !mt_wr)
      m_mtime = m_mtime + 64'd1;
  endtask

  task automatic run_cycle();
    @(posedge i_clk);
    #1;
    // an offered request stays put until it is taken
    if (!(i_req_valid && !req_taken))
    begin
      req_taken = 1'b0;
      if (have_req)
      begin
        i_req_op    = nxt_op;
        i_req_addr  = nxt_addr;
        i_req_wdata = nxt_wdata;
        i_req_valid = rand_pct(valid_pct);
      end
      else
        i_req_valid = 1'b0;
    end
    i_rsp_ready = rand_pct(ready_pct);
    i_rtc_tick  = rand_pct(tick_pct);
    @(negedge i_clk);
    observe();
  endtask

  task automatic send(input clint_op_e op, input logic [CLINT_ADDR_W-1:0] addr,
                      input logic [CLINT_DATA_W-1:0] wdata);
    nxt_op    = op;
    nxt_addr  = addr;
    nxt_wdata = wdata;
    have_req  = 1'b1;
    while (have_req)
      run_cycle();
  endtask

  // wait for every outstanding response and then a few idle cycles to catch extras
  task automatic drain();
    have_req = 1'b0;
    while (exp_rdata_q.size() != 0)
      run_cycle();
    repeat (4) run_cycle();
    // nothing is owed any more so a pending response is an extra one
    check_flag("o_rsp_valid", 1'b0, o_rsp_valid);
  endtask

  task automatic read_all();
    for (int h = 0; h < N_HARTS; h++)
    begin
      send(OP_READ, slot_addr(K_MSIP, h), '0);
      send(OP_READ, slot_addr(K_CMP_LO, h), '0);
      send(OP_READ, slot_addr(K_CMP_HI, h), '0);
    end
    send(OP_READ, CLINT_MTIME_LO, '0);
    send(OP_READ, CLINT_MTIME_HI, '0);
  endtask

  function automatic logic [N_HARTS-1:0] exp_mtip();
    logic [N_HARTS-1:0] v;
    for (int h = 0; h < N_HARTS; h++)
      v[h] = (m_mtime >= m_cmp[h]);
    return v;
  endfunction

  task automatic check_idle_irq();
    check_irq("o_msip", m_msip, o_msip);
    check_irq("o_mtip", exp_mtip(), o_mtip);
  endtask

  task automatic end_test(input string name);
    $display("test %s finished: %0d errors, %0d checks so far", name, n_errors - err0, n_checks);
    err0 = n_errors;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req_op    = OP_READ;
    i_req_addr  = '0;
    i_req_wdata = '0;
    i_rsp_ready = 1'b0;
    i_rtc_tick  = 1'b0;
    m_mtime     = '0;
    m_msip      = '0;
    for (int h = 0; h < N_HARTS; h++)
      m_cmp[h] = '1;
    have_req  = 1'b0;
    req_taken = 1'b0;
    n_checks  = 0;
    n_errors  = 0;
    err0      = 0;
    repeat (RST_CYCLES) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    @(negedge i_clk);

    // reset values
    check_flag("o_req_ready", 1'b1, o_req_ready);
    check_flag("o_rsp_valid", 1'b0, o_rsp_valid);
    check_idle_irq();
    valid_pct = 100;
    ready_pct = 100;
    tick_pct  = 0;
    read_all();
    drain();
    check_idle_irq();
    end_test("reset_values");

    // msip and mtimecmp traffic
    valid_pct = 70;
    ready_pct = 80;
    for (int i = 0; i < N_T2; i++)
      send(clint_op_e'(rand_below(2)), slot_addr(rand_below(3), rand_below(N_HARTS)),
           $random(seed));
    drain();
    check_irq("o_msip", m_msip, o_msip);
    end_test("slot_registers");

    // mtime writes, reads, ticks and compare
    for (int h = 0; h < N_HARTS; h++)
      send(OP_WRITE, slot_addr(K_CMP_HI, h), '0);
    for (int r = 0; r < N_T3_ROUNDS; r++)
    begin
      tick_pct = 50;
      for (int i = 0; i < 12; i++)
      begin
        case (rand_below(6))
          0: send(OP_WRITE, CLINT_MTIME_LO, CLINT_DATA_W'(rand_below(256)));
          1: send(OP_WRITE, CLINT_MTIME_HI, '0);
          2: send(OP_READ, CLINT_MTIME_LO, '0);
          3: send(OP_READ, CLINT_MTIME_HI, '0);
          // compare values close to the running timer
          4: send(OP_WRITE, slot_addr(K_CMP_LO, rand_below(N_HARTS)),
                  m_mtime[31:0] + CLINT_DATA_W'(rand_below(32)) - 32'd16);
          default: send(OP_WRITE, slot_addr(K_CMP_HI, rand_below(N_HARTS)), '0);
        endcase
      end
      tick_pct = 0;
      drain();
      check_idle_irq();
    end
    end_test("mtime_and_mtip");

    // error addresses leave the state alone
    for (int i = 0; i < N_T4 - N_READ_ALL; i++)
      send(clint_op_e'(rand_below(2)), bad_addr(), $random(seed));
    read_all();
    drain();
    check_idle_irq();
    end_test("error_addresses");

    // back to back requests under back-pressure
    valid_pct = 100;
    ready_pct = 30;
    tick_pct  = 50;
    for (int i = 0; i < N_T5; i++)
    begin
      case (rand_below(8))
        0: send(clint_op_e'(rand_below(2)), bad_addr(), $random(seed));
        1: send(clint_op_e'(rand_below(2)), rand_below(2) ? CLINT_MTIME_HI : CLINT_MTIME_LO,
                CLINT_DATA_W'(rand_below(256)));
        default: send(clint_op_e'(rand_below(2)),
                      slot_addr(rand_below(3), rand_below(N_HARTS)), $random(seed));
      endcase
    end
    tick_pct = 0;
    drain();
    check_idle_irq();
    end_test("back_pressure");

    $display("closing count: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== sources.f ====
hw/clint_pkg.sv
hw/clint_req_decode.sv
hw/clint_hart_slot.sv
hw/clint_rsp_collect.sv
hw/clint_cluster.sv
bench/tb_clint_cluster.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the clint testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_clint_cluster -o sim_clint > build.log 2>&1 \
  || { cat build.log; echo "build error"; exit 1; }

./obj_dir/sim_clint > sim.log 2>&1 \
  || { cat sim.log; echo "simulator exited with an error"; exit 1; }

cat sim.log

grep -q "Checks failed" sim.log && { echo "simulation reported failures"; exit 1; }

echo "simulation clean"
exit 0
